/* tb.f */
verilog/simd_alu_pkg.sv
verilog/alu_decode_stage.sv
verilog/lane_adder.sv
verilog/lane_shifter.sv
verilog/lane_compare.sv
verilog/alu_result_stage.sv
verilog/simd_alu_top.sv
dv/simd_alu_tb.sv

/* Bender.yml */
package:
  name: simd_alu

sources:
  - verilog/simd_alu_pkg.sv
  - verilog/alu_decode_stage.sv
  - verilog/lane_adder.sv
  - verilog/lane_shifter.sv
  - verilog/lane_compare.sv
  - verilog/alu_result_stage.sv
  - verilog/simd_alu_top.sv
  - target: test
    files:
      - dv/simd_alu_tb.sv

/* dv/simd_alu_tb.sv */
// simd alu testbench
`timescale 1ns/1ps

module simd_alu_tb;

  localparam int HALF_PERIOD = 2;
  localparam int RST_CYCLES  = 4;
  localparam int N_CORNER    = 6;
  localparam int N_RAND      = 6;

  // one expected result tagged with the cycle it must show up in
  typedef struct packed {
    simd_alu_pkg::alu_op_e op;
    logic [31:0]           result;
    logic                  flag;
    int                    due;
  } exp_t;

  logic                            clk_i;
  logic                            rst_n_i;
  logic                            valid_i;
  simd_alu_pkg::alu_req_t          req_i;
  logic                            valid_o;
  logic [simd_alu_pkg::DATA_W-1:0] result_o;
  logic                            cmp_flag_o;

  exp_t   exp_q[$];
  integer seed;
  int     cycles   = 0;
  int     sent_cnt = 0;

  simd_alu_top simd_alu_top_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .req_i      (req_i),
    .valid_o    (valid_o),
    .result_o   (result_o),
    .cmp_flag_o (cmp_flag_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #HALF_PERIOD clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // computed lane by lane from the op definitions
  function automatic exp_t ref_alu(input simd_alu_pkg::alu_req_t req);
    exp_t               e;
    int                 w;
    int                 n;
    int                 amt;
    logic [31:0]        mask;
    logic [31:0]        la;
    logic [31:0]        lb;
    logic [31:0]        r;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic               cond;
    logic               is_cmp;
    e = '0;
    case (req.vec_mode)
      simd_alu_pkg::VEC_MODE16: w = 16;
      simd_alu_pkg::VEC_MODE8:  w = 8;
      default:                  w = 32;
    endcase
    n    = 32 / w;
    mask = (w == 32) ? 32'hFFFF_FFFF : ((32'd1 << w) - 32'd1);
    is_cmp = (req.op >= simd_alu_pkg::ALU_EQ) && (req.op <= simd_alu_pkg::ALU_GEU);
    for (int l = 0; l < n; l++) begin
      la = (req.a >> (l * w)) & mask;
      lb = (req.b >> (l * w)) & mask;
      // sign extend each lane for the signed ops
      sa = la << (32 - w);
      sa = sa >>> (32 - w);
      sb = lb << (32 - w);
      sb = sb >>> (32 - w);
      // amount is log2(w) low bits of the lane
      amt  = lb & (w - 1);
      cond = 1'b0;
      r    = '0;
      case (req.op)
        simd_alu_pkg::ALU_ADD:  r = la + lb;
        simd_alu_pkg::ALU_SUB:  r = la - lb;
        simd_alu_pkg::ALU_AND:  r = la & lb;
        simd_alu_pkg::ALU_OR:   r = la | lb;
        simd_alu_pkg::ALU_XOR:  r = la ^ lb;
        simd_alu_pkg::ALU_SLL:  r = la << amt;
        simd_alu_pkg::ALU_SRL:  r = la >> amt;
        simd_alu_pkg::ALU_SRA:  r = sa >>> amt;
        simd_alu_pkg::ALU_EQ:   cond = (la == lb);
        simd_alu_pkg::ALU_NE:   cond = (la != lb);
        simd_alu_pkg::ALU_LTS:  cond = (sa < sb);
        simd_alu_pkg::ALU_LTU:  cond = (la < lb);
        simd_alu_pkg::ALU_GES:  cond = (sa >= sb);
        simd_alu_pkg::ALU_GEU:  cond = (la >= lb);
        simd_alu_pkg::ALU_MIN:  r = (sa < sb) ? la : lb;
        simd_alu_pkg::ALU_MINU: r = (la < lb) ? la : lb;
        simd_alu_pkg::ALU_MAX:  r = (sa > sb) ? la : lb;
        simd_alu_pkg::ALU_MAXU: r = (la > lb) ? la : lb;
        // most negative lane wraps back onto itself
        simd_alu_pkg::ALU_ABS:  r = (sa < 0) ? (32'd0 - la) : la;
        default: ;
      endcase
      if (is_cmp) begin
        r = cond ? mask : '0;
        if (l == n - 1) begin
          e.flag = cond;
        end
      end
      e.result = e.result | ((r & mask) << (l * w));
    end
    // relu looks at the whole word sign
    if (req.op == simd_alu_pkg::ALU_RELU) begin
      if ($signed(req.a) < 0) begin
        e.result = 32'd0;
      end else begin
        e.result = req.a;
      end
    end
    return e;
  endfunction

  ////////////////////////////////////////
  // checking
  ////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk_i) begin
    exp_t e;
    logic due_now;
    due_now = 1'b0;
    if (exp_q.size() > 0) begin
      due_now = (exp_q[0].due == cycles);
    end
    check_value("valid_o", valid_o, due_now);
    if (valid_o) begin
      e = exp_q.pop_front();
      check_value($sformatf("result_o of %s", e.op.name()), result_o, e.result);
      check_value($sformatf("cmp_flag_o of %s", e.op.name()), cmp_flag_o, e.flag);
    end
  end

  // each request needs at most one gap slot plus pipeline drain
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > RST_CYCLES + 2 * sent_cnt + 20) begin
      $display("timeout after %0d cycles, results stopped arriving", cycles);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // one request that sometimes follows an idle cycle
  task automatic send(input simd_alu_pkg::alu_op_e op, input simd_alu_pkg::vec_mode_e mode,
                      input logic [31:0] a, input logic [31:0] b);
    simd_alu_pkg::alu_req_t req;
    exp_t                   e;
    req.op       = op;
    req.vec_mode = mode;
    req.a        = a;
    req.b        = b;
    if (($random(seed) & 3) == 0) begin
      @(negedge clk_i);
      valid_i = 1'b0;
    end
    @(negedge clk_i);
    valid_i = 1'b1;
    req_i   = req;
    e       = ref_alu(req);
    e.op    = op;
    e.due   = cycles + 2;
    exp_q.push_back(e);
    sent_cnt++;
  endtask

  function automatic simd_alu_pkg::vec_mode_e mode_of(input int m);
    case (m)
      1:       return simd_alu_pkg::VEC_MODE16;
      2:       return simd_alu_pkg::VEC_MODE8;
      default: return simd_alu_pkg::VEC_MODE32;
    endcase
  endfunction

  // lane boundary carries, sign boundaries, equal operands
  function automatic logic [63:0] corner_pair(input int idx);
    case (idx)
      0:       return {32'h00FF_00FF, 32'h0001_0001};
      1:       return {32'h8080_8080, 32'h7F7F_7F7F};
      2:       return {32'h1234_5678, 32'h1234_5678};
      3:       return {32'h8000_0000, 32'h0000_0000};
      4:       return {32'hFFFF_FFFF, 32'h0000_0001};
      default: return {32'h7FFF_8000, 32'h8000_7FFF};
    endcase
  endfunction

  initial begin
    logic [63:0] pair;
    seed    = 43;
    rst_n_i = 1'b0;
    valid_i = 1'b0;
    req_i   = '0;
    repeat (RST_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;
    // directed corners for every op and mode
    for (int p = 0; p < N_CORNER; p++) begin
      pair = corner_pair(p);
      for (int m = 0; m < 3; m++) begin
        for (int o = 0; o <= int'(simd_alu_pkg::ALU_ABS); o++) begin
          send(simd_alu_pkg::alu_op_e'(o), mode_of(m), pair[63:32], pair[31:0]);
        end
      end
    end
    // random operands and shift amounts
    for (int k = 0; k < N_RAND; k++) begin
      for (int m = 0; m < 3; m++) begin
        for (int o = 0; o <= int'(simd_alu_pkg::ALU_ABS); o++) begin
          send(simd_alu_pkg::alu_op_e'(o), mode_of(m), $random(seed), $random(seed));
        end
      end
    end
    @(negedge clk_i);
    valid_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    // valid_o must stay low once drained
    repeat (3) @(negedge clk_i);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* verilog/simd_alu_top.sv */
// simd alu top level
`timescale 1ns/1ps

module simd_alu_top (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              valid_i,
  input  simd_alu_pkg::alu_req_t            req_i,
  output logic                              valid_o,
  output logic [simd_alu_pkg::DATA_W-1:0]   result_o,
  output logic                              cmp_flag_o
);

  // stage 1 registers
  simd_alu_pkg::alu_req_t                req_q;
  simd_alu_pkg::alu_ctrl_t               ctrl_q;
  logic                                  valid_q;

  // unit outputs are combinational off the stage 1 registers
  logic [simd_alu_pkg::DATA_W-1:0]       sum;
  logic [simd_alu_pkg::DATA_W-1:0]       shift_res;
  logic [simd_alu_pkg::LANE_MAX-1:0]     is_equal;
  logic [simd_alu_pkg::LANE_MAX-1:0]     is_greater;
  logic [simd_alu_pkg::DATA_W-1:0]       minmax_res;

  alu_decode_stage alu_decode_stage_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .req_i   (req_i),
    .valid_o (valid_q),
    .req_o   (req_q),
    .ctrl_o  (ctrl_q)
  );

  lane_adder lane_adder_i (
    .req_i  (req_q),
    .ctrl_i (ctrl_q),
    .sum_o  (sum)
  );

  lane_shifter lane_shifter_i (
    .req_i   (req_q),
    .ctrl_i  (ctrl_q),
    .shift_o (shift_res)
  );

  // abs takes zero minus a from the adder as its b side
  lane_compare lane_compare_i (
    .req_i        (req_q),
    .ctrl_i       (ctrl_q),
    .neg_a_i      (sum),
    .is_equal_o   (is_equal),
    .is_greater_o (is_greater),
    .minmax_o     (minmax_res)
  );

  alu_result_stage alu_result_stage_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .valid_i      (valid_q),
    .req_i        (req_q),
    .ctrl_i       (ctrl_q),
    .sum_i        (sum),
    .shift_i      (shift_res),
    .is_equal_i   (is_equal),
    .is_greater_i (is_greater),
    .minmax_i     (minmax_res),
    .valid_o      (valid_o),
    .result_o     (result_o),
    .cmp_flag_o   (cmp_flag_o)
  );

endmodule

/* verilog/alu_result_stage.sv */
// result mux and output registers
`timescale 1ns/1ps

module alu_result_stage (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              valid_i,
  input  simd_alu_pkg::alu_req_t            req_i,
  input  simd_alu_pkg::alu_ctrl_t           ctrl_i,
  input  logic [simd_alu_pkg::DATA_W-1:0]   sum_i,
  input  logic [simd_alu_pkg::DATA_W-1:0]   shift_i,
  input  logic [simd_alu_pkg::LANE_MAX-1:0] is_equal_i,
  input  logic [simd_alu_pkg::LANE_MAX-1:0] is_greater_i,
  input  logic [simd_alu_pkg::DATA_W-1:0]   minmax_i,
  output logic                              valid_o,
  output logic [simd_alu_pkg::DATA_W-1:0]   result_o,
  output logic                              cmp_flag_o
);

  logic [simd_alu_pkg::LANE_MAX-1:0] lane_cond;
  logic [simd_alu_pkg::DATA_W-1:0]   cmp_mask;
  logic [simd_alu_pkg::DATA_W-1:0]   logic_res;
  logic [simd_alu_pkg::DATA_W-1:0]   result_d;
  logic                              flag_d;

  // eq, ne, lt and ge from two flags
  assign lane_cond = (ctrl_i.cmp_or_eq ? (is_greater_i | is_equal_i) : is_equal_i) ^
                     {simd_alu_pkg::LANE_MAX{ctrl_i.cmp_invert}};

  // spread each lane bit over its byte
  always_comb begin
    for (int i = 0; i < simd_alu_pkg::LANE_MAX; i++) begin
      cmp_mask[i*simd_alu_pkg::BYTE_W +: simd_alu_pkg::BYTE_W] =
        {simd_alu_pkg::BYTE_W{lane_cond[i]}};
    end
  end

  always_comb begin
    case (req_i.op)
      simd_alu_pkg::ALU_OR:  logic_res = req_i.a | req_i.b;
      simd_alu_pkg::ALU_XOR: logic_res = req_i.a ^ req_i.b;
      default:               logic_res = req_i.a & req_i.b;
    endcase
  end

  ////////////////////////////////////////
  // result select
  ////////////////////////////////////////

  always_comb begin
    flag_d = 1'b0;
    case (ctrl_i.res_sel)
      simd_alu_pkg::RES_LOGIC:  result_d = logic_res;
      // relu clamps a negative word to zero
      simd_alu_pkg::RES_RELU:
        result_d = req_i.a[simd_alu_pkg::DATA_W-1] ? '0 : req_i.a;
      simd_alu_pkg::RES_SHIFT:  result_d = shift_i;
      simd_alu_pkg::RES_MINMAX: result_d = minmax_i;
      simd_alu_pkg::RES_CMP: begin
        result_d = cmp_mask;
        flag_d   = lane_cond[simd_alu_pkg::LANE_MAX-1];
      end
      default:                  result_d = sum_i;
    endcase
  end

  // result holds between pulses
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o    <= 1'b0;
      result_o   <= '0;
      cmp_flag_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o   <= result_d;
        cmp_flag_o <= flag_d;
      end
    end
  end

endmodule

/* verilog/lane_compare.sv */
// per lane compare and min max
`timescale 1ns/1ps

module lane_compare (
  input  simd_alu_pkg::alu_req_t            req_i,
  input  simd_alu_pkg::alu_ctrl_t           ctrl_i,
  input  logic [simd_alu_pkg::DATA_W-1:0]   neg_a_i,
  output logic [simd_alu_pkg::LANE_MAX-1:0] is_equal_o,
  output logic [simd_alu_pkg::LANE_MAX-1:0] is_greater_o,
  output logic [simd_alu_pkg::DATA_W-1:0]   minmax_o
);

  logic [simd_alu_pkg::DATA_W-1:0]   cmp_b;
  logic [simd_alu_pkg::LANE_MAX-1:0] lane_top;
  logic [simd_alu_pkg::LANE_MAX-1:0] eq_byte;
  logic [simd_alu_pkg::LANE_MAX-1:0] gt_byte;
  logic [simd_alu_pkg::LANE_MAX-1:0] sel_a;

  // abs compares a against its own negation
  assign cmp_b = ctrl_i.abs_mode ? neg_a_i : req_i.b;

  // bytes holding a lane sign bit
  always_comb begin
    case (req_i.vec_mode)
      simd_alu_pkg::VEC_MODE8:  lane_top = 4'b1111;
      simd_alu_pkg::VEC_MODE16: lane_top = 4'b1010;
      default:                  lane_top = 4'b1000;
    endcase
  end

  // byte level equal and greater with sign extension only at a lane top
  always_comb begin
    for (int i = 0; i < simd_alu_pkg::LANE_MAX; i++) begin
      eq_byte[i] = req_i.a[i*simd_alu_pkg::BYTE_W +: simd_alu_pkg::BYTE_W] ==
                   cmp_b[i*simd_alu_pkg::BYTE_W +: simd_alu_pkg::BYTE_W];
      gt_byte[i] = $signed({req_i.a[i*simd_alu_pkg::BYTE_W+simd_alu_pkg::BYTE_W-1] &
                            ctrl_i.cmp_signed & lane_top[i],
                            req_i.a[i*simd_alu_pkg::BYTE_W +: simd_alu_pkg::BYTE_W]}) >
                   $signed({cmp_b[i*simd_alu_pkg::BYTE_W+simd_alu_pkg::BYTE_W-1] &
                            ctrl_i.cmp_signed & lane_top[i],
                            cmp_b[i*simd_alu_pkg::BYTE_W +: simd_alu_pkg::BYTE_W]});
    end
  end

  // chain bytes into lanes where the upper byte decides unless equal
  always_comb begin
    case (req_i.vec_mode)
      simd_alu_pkg::VEC_MODE8: begin
        is_equal_o   = eq_byte;
        is_greater_o = gt_byte;
      end
      simd_alu_pkg::VEC_MODE16: begin
        is_equal_o   = {{2{eq_byte[3] & eq_byte[2]}}, {2{eq_byte[1] & eq_byte[0]}}};
        is_greater_o = {{2{gt_byte[3] | (eq_byte[3] & gt_byte[2])}},
                        {2{gt_byte[1] | (eq_byte[1] & gt_byte[0])}}};
      end
      default: begin
        is_equal_o   = {simd_alu_pkg::LANE_MAX{&eq_byte}};
        is_greater_o = {simd_alu_pkg::LANE_MAX{gt_byte[3] | (eq_byte[3] & (gt_byte[2] |
                        (eq_byte[2] & (gt_byte[1] | (eq_byte[1] & gt_byte[0])))))}};
      end
    endcase
  end

  // take a where it wins and b otherwise
  assign sel_a = is_greater_o ^ {simd_alu_pkg::LANE_MAX{ctrl_i.do_min}};

  always_comb begin
    for (int i = 0; i < simd_alu_pkg::LANE_MAX; i++) begin
      minmax_o[i*simd_alu_pkg::BYTE_W +: simd_alu_pkg::BYTE_W] = sel_a[i] ?
        req_i.a[i*simd_alu_pkg::BYTE_W +: simd_alu_pkg::BYTE_W] :
        cmp_b[i*simd_alu_pkg::BYTE_W +: simd_alu_pkg::BYTE_W];
    end
  end

endmodule

/* verilog/lane_shifter.sv */
// per lane shifter
`timescale 1ns/1ps

module lane_shifter (
  input  simd_alu_pkg::alu_req_t          req_i,
  input  simd_alu_pkg::alu_ctrl_t         ctrl_i,
  output logic [simd_alu_pkg::DATA_W-1:0] shift_o
);

  logic [simd_alu_pkg::DATA_W-1:0] op_a;
  logic [simd_alu_pkg::DATA_W-1:0] amt_rev;
  logic [simd_alu_pkg::DATA_W-1:0] amt;
  logic [simd_alu_pkg::DATA_W-1:0] shr_res;

  function automatic logic [simd_alu_pkg::DATA_W-1:0] bit_rev(
    input logic [simd_alu_pkg::DATA_W-1:0] v
  );
    logic [simd_alu_pkg::DATA_W-1:0] r;
    for (int k = 0; k < simd_alu_pkg::DATA_W; k++) begin
      r[k] = v[simd_alu_pkg::DATA_W-1-k];
    end
    return r;
  endfunction

  // left shift runs through the right shifter on reversed data
  assign op_a = ctrl_i.shift_left ? bit_rev(req_i.a) : req_i.a;

  // reversing the data also swaps the lane order of the amounts
  always_comb begin
    case (req_i.vec_mode)
      simd_alu_pkg::VEC_MODE16: amt_rev = {req_i.b[15:0], req_i.b[31:16]};
      simd_alu_pkg::VEC_MODE8:
        amt_rev = {req_i.b[7:0], req_i.b[15:8], req_i.b[23:16], req_i.b[31:24]};
      default: amt_rev = req_i.b;
    endcase
  end

  assign amt = ctrl_i.shift_left ? amt_rev : req_i.b;

  ////////////////////////////////////////
  // right shifter with sign fill per lane
  ////////////////////////////////////////

  always_comb begin
    logic [2*simd_alu_pkg::DATA_W-1:0] wide;
    wide    = '0;
    shr_res = '0;
    case (req_i.vec_mode)
      simd_alu_pkg::VEC_MODE16: begin
        for (int h = 0; h < 2; h++) begin
          wide = {{simd_alu_pkg::HALF_W{ctrl_i.shift_arith &
                   op_a[h*simd_alu_pkg::HALF_W+simd_alu_pkg::HALF_W-1]}},
                  op_a[h*simd_alu_pkg::HALF_W +: simd_alu_pkg::HALF_W]}
                 >> amt[h*simd_alu_pkg::HALF_W +: simd_alu_pkg::SH16_W];
          shr_res[h*simd_alu_pkg::HALF_W +: simd_alu_pkg::HALF_W] =
            wide[simd_alu_pkg::HALF_W-1:0];
        end
      end
      simd_alu_pkg::VEC_MODE8: begin
        for (int i = 0; i < simd_alu_pkg::LANE_MAX; i++) begin
          wide = {{simd_alu_pkg::BYTE_W{ctrl_i.shift_arith &
                   op_a[i*simd_alu_pkg::BYTE_W+simd_alu_pkg::BYTE_W-1]}},
                  op_a[i*simd_alu_pkg::BYTE_W +: simd_alu_pkg::BYTE_W]}
                 >> amt[i*simd_alu_pkg::BYTE_W +: simd_alu_pkg::SH8_W];
          shr_res[i*simd_alu_pkg::BYTE_W +: simd_alu_pkg::BYTE_W] =
            wide[simd_alu_pkg::BYTE_W-1:0];
        end
      end
      default: begin
        wide = {{simd_alu_pkg::DATA_W{ctrl_i.shift_arith & op_a[simd_alu_pkg::DATA_W-1]}},
                op_a} >> amt[simd_alu_pkg::SH32_W-1:0];
        shr_res = wide[simd_alu_pkg::DATA_W-1:0];
      end
    endcase
  end

  // undo the reversal for left shifts
  assign shift_o = ctrl_i.shift_left ? bit_rev(shr_res) : shr_res;

endmodule

/* verilog/lane_adder.sv */
// lane partitioned adder
`timescale 1ns/1ps

module lane_adder (
  input  simd_alu_pkg::alu_req_t          req_i,
  input  simd_alu_pkg::alu_ctrl_t         ctrl_i,
  output logic [simd_alu_pkg::DATA_W-1:0] sum_o
);

  logic [simd_alu_pkg::DATA_W-1:0]   op_a;
  logic [simd_alu_pkg::DATA_W-1:0]   op_b;
  logic [simd_alu_pkg::LANE_MAX-1:0] lane_start;
  logic                              carry_in;
  logic [simd_alu_pkg::ADD_W-1:0]    in_a;
  logic [simd_alu_pkg::ADD_W-1:0]    in_b;
  logic [simd_alu_pkg::ADD_W-1:0]    add_res;

  // abs takes ~a + 0 + 1 and sub takes a + ~b + 1
  assign op_a     = ctrl_i.abs_mode ? ~req_i.a : req_i.a;
  assign op_b     = ctrl_i.abs_mode ? '0 : (ctrl_i.negate_b ? ~req_i.b : req_i.b);
  assign carry_in = ctrl_i.negate_b | ctrl_i.abs_mode;

  // bytes that begin a new lane
  always_comb begin
    lane_start    = '0;
    lane_start[0] = 1'b1;
    case (req_i.vec_mode)
      simd_alu_pkg::VEC_MODE16: lane_start[simd_alu_pkg::LANE_MAX/2] = 1'b1;
      simd_alu_pkg::VEC_MODE8:  lane_start = '1;
      default: ;
    endcase
  end

  // break bit below each byte
  // 1/0 passes the carry, 0/0 kills it, 1/1 injects the +1 of a negate
  always_comb begin
    for (int i = 0; i < simd_alu_pkg::LANE_MAX; i++) begin
      if (lane_start[i]) begin
        in_a[i*simd_alu_pkg::SLOT_W] = carry_in;
        in_b[i*simd_alu_pkg::SLOT_W] = carry_in;
      end else begin
        in_a[i*simd_alu_pkg::SLOT_W] = 1'b1;
        in_b[i*simd_alu_pkg::SLOT_W] = 1'b0;
      end
      in_a[i*simd_alu_pkg::SLOT_W+1 +: simd_alu_pkg::BYTE_W] =
        op_a[i*simd_alu_pkg::BYTE_W +: simd_alu_pkg::BYTE_W];
      in_b[i*simd_alu_pkg::SLOT_W+1 +: simd_alu_pkg::BYTE_W] =
        op_b[i*simd_alu_pkg::BYTE_W +: simd_alu_pkg::BYTE_W];
    end
  end

  // one wide add drops the carry out of the top lane
  assign add_res = in_a + in_b;

  // strip the break bits again
  always_comb begin
    for (int i = 0; i < simd_alu_pkg::LANE_MAX; i++) begin
      sum_o[i*simd_alu_pkg::BYTE_W +: simd_alu_pkg::BYTE_W] =
        add_res[i*simd_alu_pkg::SLOT_W+1 +: simd_alu_pkg::BYTE_W];
    end
  end

endmodule

/* verilog/alu_decode_stage.sv */
// request decode stage
`timescale 1ns/1ps

module alu_decode_stage (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    valid_i,
  input  simd_alu_pkg::alu_req_t  req_i,
  output logic                    valid_o,
  output simd_alu_pkg::alu_req_t  req_o,
  output simd_alu_pkg::alu_ctrl_t ctrl_o
);

  simd_alu_pkg::alu_ctrl_t ctrl_d;

  ////////////////////////////////////////
  // opcode decode
  ////////////////////////////////////////

  always_comb begin
    // unknown opcodes fall back to a plain add
    ctrl_d = '0;
    ctrl_d.res_sel = simd_alu_pkg::RES_ADD;
    case (req_i.op)
      simd_alu_pkg::ALU_ADD: ;
      simd_alu_pkg::ALU_SUB: begin
        ctrl_d.negate_b   = 1'b1;
        ctrl_d.cmp_signed = 1'b1;
      end
      simd_alu_pkg::ALU_AND,
      simd_alu_pkg::ALU_OR,
      simd_alu_pkg::ALU_XOR: ctrl_d.res_sel = simd_alu_pkg::RES_LOGIC;
      simd_alu_pkg::ALU_RELU: ctrl_d.res_sel = simd_alu_pkg::RES_RELU;
      simd_alu_pkg::ALU_SLL: begin
        ctrl_d.res_sel    = simd_alu_pkg::RES_SHIFT;
        ctrl_d.shift_left = 1'b1;
      end
      simd_alu_pkg::ALU_SRL: ctrl_d.res_sel = simd_alu_pkg::RES_SHIFT;
      simd_alu_pkg::ALU_SRA: begin
        ctrl_d.res_sel     = simd_alu_pkg::RES_SHIFT;
        ctrl_d.shift_arith = 1'b1;
      end
      // compare mask is (or_eq ? gt|eq : eq) ^ invert
      simd_alu_pkg::ALU_EQ: ctrl_d.res_sel = simd_alu_pkg::RES_CMP;
      simd_alu_pkg::ALU_NE: begin
        ctrl_d.res_sel    = simd_alu_pkg::RES_CMP;
        ctrl_d.cmp_invert = 1'b1;
      end
      simd_alu_pkg::ALU_LTS,
      simd_alu_pkg::ALU_LTU: begin
        ctrl_d.res_sel    = simd_alu_pkg::RES_CMP;
        ctrl_d.cmp_signed = (req_i.op == simd_alu_pkg::ALU_LTS);
        ctrl_d.cmp_or_eq  = 1'b1;
        ctrl_d.cmp_invert = 1'b1;
      end
      simd_alu_pkg::ALU_GES,
      simd_alu_pkg::ALU_GEU: begin
        ctrl_d.res_sel    = simd_alu_pkg::RES_CMP;
        ctrl_d.cmp_signed = (req_i.op == simd_alu_pkg::ALU_GES);
        ctrl_d.cmp_or_eq  = 1'b1;
      end
      simd_alu_pkg::ALU_MIN,
      simd_alu_pkg::ALU_MINU,
      simd_alu_pkg::ALU_MAX,
      simd_alu_pkg::ALU_MAXU: begin
        ctrl_d.res_sel    = simd_alu_pkg::RES_MINMAX;
        ctrl_d.cmp_signed = (req_i.op == simd_alu_pkg::ALU_MIN) ||
                            (req_i.op == simd_alu_pkg::ALU_MAX);
        ctrl_d.do_min     = (req_i.op == simd_alu_pkg::ALU_MIN) ||
                            (req_i.op == simd_alu_pkg::ALU_MINU);
      end
      // abs is the signed max of a and zero minus a
      simd_alu_pkg::ALU_ABS: begin
        ctrl_d.res_sel    = simd_alu_pkg::RES_MINMAX;
        ctrl_d.abs_mode   = 1'b1;
        ctrl_d.cmp_signed = 1'b1;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // stage registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // payload only loads on a request
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      req_o  <= req_i;
      ctrl_o <= ctrl_d;
    end
  end

endmodule

/* verilog/simd_alu_pkg.sv */
// simd alu shared definitions
package simd_alu_pkg;

  ////////////////////////////////////////
  // widths and lane constants
  ////////////////////////////////////////

  // datapath width is one 32-bit lane at most
  localparam int DATA_W   = 32;
  // byte lanes are the smallest unit
  localparam int LANE_MAX = 4;
  localparam int BYTE_W   = 8;
  localparam int HALF_W   = 16;

  // adder slot is one byte plus one carry-break bit
  localparam int SLOT_W   = BYTE_W + 1;
  localparam int ADD_W    = LANE_MAX * SLOT_W;

  // shift amount widths per lane size
  localparam int SH32_W   = 5;
  localparam int SH16_W   = 4;
  localparam int SH8_W    = 3;

  ////////////////////////////////////////
  // enums
  ////////////////////////////////////////

  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_RELU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_EQ,
    ALU_NE,
    ALU_LTS,
    ALU_LTU,
    ALU_GES,
    ALU_GEU,
    ALU_MIN,
    ALU_MINU,
    ALU_MAX,
    ALU_MAXU,
    ALU_ABS
  } alu_op_e;

  // lane split into one, two or four lanes
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  // which unit feeds the output register
  typedef enum logic [2:0] {
    RES_ADD,
    RES_LOGIC,
    RES_RELU,
    RES_SHIFT,
    RES_CMP,
    RES_MINMAX
  } res_sel_e;

  ////////////////////////////////////////
  // structs
  ////////////////////////////////////////

  // one request of 71 bits
  typedef struct packed {
    alu_op_e             op;
    vec_mode_e           vec_mode;
    logic [DATA_W-1:0]   a;
    logic [DATA_W-1:0]   b;
  } alu_req_t;

  // decoded controls
  typedef struct packed {
    logic     negate_b;
    logic     abs_mode;
    logic     cmp_signed;
    logic     shift_left;
    logic     shift_arith;
    logic     do_min;
    logic     cmp_invert;
    logic     cmp_or_eq;
    res_sel_e res_sel;
  } alu_ctrl_t;

endpackage
